//--- logic/ps2_frame_pkg.sv
// frames are 11 bits sent LSB first with odd parity, and the receive side never checks parity
`default_nettype none

package ps2_frame_pkg;

  // ---------------------------------------------------------------------------
  // frame layout
  // ---------------------------------------------------------------------------

  // start bit, eight data bits LSB first, odd parity and a stop bit
  parameter int frame_bits = 11;

  // transmit shift count at which the stop bit sits on the data wire
  parameter int tx_shift_bits = 10;

  typedef logic [7:0] byte_t;

  // bit 0 is the start bit and bit frame_bits-1 the stop bit
  typedef logic [frame_bits-1:0] frame_t;

  // ---------------------------------------------------------------------------
  // line types
  // ---------------------------------------------------------------------------

  // synchronized levels of the two wires, both high when the bus is idle
  typedef struct packed {
    logic clk;
    logic data;
  } line_s;

  // pull-low requests toward the pads, active high
  typedef struct packed {
    logic clk_low;
    logic data_low;
  } drive_s;

  // one-cycle markers of a clock wire transition
  typedef struct packed {
    logic fall;
    logic rise;
  } edge_s;

endpackage

`default_nettype wire

//--- logic/ps2_ctrl_pkg.sv
// controller types only, so the owner and transmit encodings may change without touching the wire types
`default_nettype none

package ps2_ctrl_pkg;

  // which engine currently owns the two wires
  typedef enum logic {
    rx,
    tx
  } owner_e;

  // transmit machine, idle is where it waits while receive owns the wires
  typedef enum logic [3:0] {
    idle,
    force_clk_low,
    first_wait_clk_high,
    wait_clk_high,
    clk_high,
    clk_low,
    wait_ack,
    done_recovery,
    error_no_ack
  } tx_state_e;

  // enables of the 60 us timer and of the debounce timer
  typedef struct packed {
    logic run_long;
    logic run_short;
  } timer_req_s;

  // a done bit stays high for as long as its enable stays high
  typedef struct packed {
    logic long_done;
    logic short_done;
  } timer_done_s;

endpackage

`default_nettype wire

//--- logic/ps2_line_sync.sv
// wires are sampled with no filtering, so a change reaches line_o after 2 cycles and edge_o after 3
`default_nettype none
`timescale 1ns/10ps

module ps2_line_sync (
  input  wire                   clk,
  input  wire                   reset,
  input  wire ps2_frame_pkg::line_s line_i,
  output ps2_frame_pkg::line_s  line_o,
  output ps2_frame_pkg::edge_s  edge_o
);

  // first stage may go metastable, the second one is what the engines see
  ps2_frame_pkg::line_s meta_q;
  ps2_frame_pkg::line_s sync_q;

  // previous synchronized clock level for edge detection
  logic clk_last_q;

  // all stages come up at the idle level of the bus
  // so that no false edge is reported after reset
  always_ff @(posedge clk or posedge reset)
  begin
    if (reset)
    begin
      meta_q     <= '1;
      sync_q     <= '1;
      clk_last_q <= 1'b1;
      edge_o     <= '0;
    end
    else
    begin
      meta_q      <= line_i;
      sync_q      <= meta_q;
      clk_last_q  <= sync_q.clk;
      // markers are registered, one cycle behind the level on line_o
      edge_o.fall <= clk_last_q & ~sync_q.clk;
      edge_o.rise <= ~clk_last_q & sync_q.clk;
    end
  end

  assign line_o = sync_q;

endmodule

`default_nettype wire

//--- logic/ps2_bit_timers.sv
// divide_i must be at least 4 so the debounce time covers the synchronizer delay
`default_nettype none
`timescale 1ns/10ps

module ps2_bit_timers #(
  parameter int timer_long_ticks = 2950,
  parameter int timer_long_bits  = 12
) (
  input  wire                            clk,
  input  wire                            reset,
  input  wire [15:0]                     divide_i,
  input  wire ps2_ctrl_pkg::timer_req_s  req_i,
  output ps2_ctrl_pkg::timer_done_s      done_o
);

  logic [15:0]                div_cnt_q;
  logic [timer_long_bits-1:0] long_cnt_q;
  logic [15:0]                short_cnt_q;
  logic                       tick;
  logic                       long_at_limit;
  logic                       short_at_limit;

  // ---------------------------------------------------------------------------
  // clock divider, one tick every divide_i cycles while the long timer runs
  // ---------------------------------------------------------------------------
  assign tick = req_i.run_long && (div_cnt_q == divide_i - 16'd1);

  always_ff @(posedge clk or posedge reset)
  begin
    if (reset)
      div_cnt_q <= '0;
    else if (!req_i.run_long || tick)
      div_cnt_q <= '0;
    else
      div_cnt_q <= div_cnt_q + 16'd1;
  end

  // ---------------------------------------------------------------------------
  // 60 us timer counts ticks and stops at its limit
  // ---------------------------------------------------------------------------
  assign long_at_limit = (long_cnt_q == timer_long_bits'(timer_long_ticks));

  always_ff @(posedge clk or posedge reset)
  begin
    if (reset)
      long_cnt_q <= '0;
    else if (!req_i.run_long)
      long_cnt_q <= '0;
    else if (tick && !long_at_limit)
      long_cnt_q <= long_cnt_q + 1'b1;
  end

  // debounce timer counts system cycles straight from its enable
  assign short_at_limit = (short_cnt_q == divide_i - 16'd1);

  always_ff @(posedge clk or posedge reset)
  begin
    if (reset)
      short_cnt_q <= '0;
    else if (!req_i.run_short)
      short_cnt_q <= '0;
    else if (!short_at_limit)
      short_cnt_q <= short_cnt_q + 16'd1;
  end

  // a dropped enable hides the done bit at once, not one cycle later
  assign done_o.long_done  = req_i.run_long && long_at_limit;
  assign done_o.short_done = req_i.run_short && short_at_limit;

endmodule

`default_nettype wire

//--- logic/ps2_rx_deframer.sv
// parity and stop bits are not checked, and a frame finished before a read overwrites the byte
`default_nettype none
`timescale 1ns/10ps

module ps2_rx_deframer (
  input  wire                             clk,
  input  wire                             reset,
  input  wire ps2_frame_pkg::line_s       line_i,
  input  wire ps2_frame_pkg::edge_s       edge_i,
  input  wire                             park_i,
  input  wire ps2_ctrl_pkg::timer_done_s  timer_i,
  input  wire                             rx_read_i,
  output logic                            run_long_o,
  output ps2_frame_pkg::byte_t            rx_data_o,
  output logic                            rx_ready_o
);

  ps2_frame_pkg::frame_t shift_q;
  logic [3:0]            bit_cnt_q;
  logic                  frame_end;
  logic                  watchdog_clear;

  // the eleventh falling edge closes the frame
  assign frame_end = edge_i.fall && (bit_cnt_q == 4'(ps2_frame_pkg::frame_bits - 1));

  // the watchdog restarts on every clock edge, so it only runs out on an idle bus
  assign run_long_o     = ~(edge_i.fall | edge_i.rise);
  assign watchdog_clear = timer_i.long_done && line_i.clk;

  // ---------------------------------------------------------------------------
  // bit counter
  // ---------------------------------------------------------------------------
  // parked while transmit owns the wires, since those clocks belong to the
  // host frame and must not be counted as received bits
  always_ff @(posedge clk or posedge reset)
  begin
    if (reset)
      bit_cnt_q <= '0;
    else if (park_i || frame_end || watchdog_clear)
      bit_cnt_q <= '0;
    else if (edge_i.fall)
      bit_cnt_q <= bit_cnt_q + 4'd1;
  end

  // bits enter at the top and move down, so the start bit ends up lowest
  always_ff @(posedge clk)
  begin
    if (edge_i.fall)
      shift_q <= {line_i.data, shift_q[ps2_frame_pkg::frame_bits-1:1]};
  end

  // on the closing edge the stop bit is still on the wire, and the data
  // bits sit one place above their final frame position
  always_ff @(posedge clk)
  begin
    if (frame_end)
      rx_data_o <= shift_q[9:2];
  end

  // ---------------------------------------------------------------------------
  // ready level
  // ---------------------------------------------------------------------------
  // a new frame wins over a read in the same cycle so no byte is lost silently
  always_ff @(posedge clk or posedge reset)
  begin
    if (reset)
      rx_ready_o <= 1'b0;
    else if (frame_end)
      rx_ready_o <= 1'b1;
    else if (rx_read_i)
      rx_ready_o <= 1'b0;
  end

endmodule

`default_nettype wire

//--- logic/ps2_tx_framer.sv
// the device must start clocking after the clock hold, because there is no timeout while waiting
`default_nettype none
`timescale 1ns/10ps

module ps2_tx_framer (
  input  wire                             clk,
  input  wire                             reset,
  input  wire                             load_i,
  input  wire ps2_frame_pkg::byte_t       tx_data_i,
  input  wire ps2_frame_pkg::line_s       line_i,
  input  wire ps2_frame_pkg::edge_s       edge_i,
  input  wire ps2_ctrl_pkg::timer_done_s  timer_i,
  output logic                            run_long_o,
  output logic                            run_short_o,
  output ps2_frame_pkg::drive_s           drive_o,
  output logic                            done_o,
  output logic                            tx_error_o
);

  ps2_ctrl_pkg::tx_state_e state_q;
  ps2_ctrl_pkg::tx_state_e state_d;
  ps2_frame_pkg::frame_t   frame_q;
  logic [3:0]              bit_cnt_q;
  logic                    shift;
  logic                    shift_done;
  logic                    lines_idle;

  assign lines_idle = line_i.clk & line_i.data;

  // a bit moves out once the clock is back high and has settled
  assign shift      = (state_q == ps2_ctrl_pkg::wait_clk_high) && line_i.clk &&
                      timer_i.short_done;
  assign shift_done = (bit_cnt_q == 4'(ps2_frame_pkg::tx_shift_bits));

  // ---------------------------------------------------------------------------
  // state machine
  // ---------------------------------------------------------------------------
  always_comb
  begin
    state_d = state_q;
    case (state_q)
      ps2_ctrl_pkg::idle:
        if (load_i)
          state_d = ps2_ctrl_pkg::force_clk_low;
      // clock held low for the full 60 us to request to send
      ps2_ctrl_pkg::force_clk_low:
        if (timer_i.long_done)
          state_d = ps2_ctrl_pkg::first_wait_clk_high;
      // start bit is on the wire, wait for the device to take the clock low
      ps2_ctrl_pkg::first_wait_clk_high:
        if (!line_i.clk && timer_i.short_done)
          state_d = ps2_ctrl_pkg::clk_low;
      ps2_ctrl_pkg::clk_low:
        if (edge_i.rise)
          state_d = ps2_ctrl_pkg::wait_clk_high;
      ps2_ctrl_pkg::wait_clk_high:
        if (shift)
          state_d = ps2_ctrl_pkg::clk_high;
      ps2_ctrl_pkg::clk_high:
        if (shift_done)
          state_d = ps2_ctrl_pkg::wait_ack;
        else if (edge_i.fall)
          state_d = ps2_ctrl_pkg::clk_low;
      // the device answers by pulling data low during its last clock low
      ps2_ctrl_pkg::wait_ack:
        if (!line_i.clk)
          state_d = line_i.data ? ps2_ctrl_pkg::error_no_ack : ps2_ctrl_pkg::done_recovery;
      ps2_ctrl_pkg::done_recovery,
      ps2_ctrl_pkg::error_no_ack:
        if (lines_idle)
          state_d = ps2_ctrl_pkg::idle;
      default:
        state_d = ps2_ctrl_pkg::idle;
    endcase
  end

  always_ff @(posedge clk or posedge reset)
  begin
    if (reset)
    begin
      state_q   <= ps2_ctrl_pkg::idle;
      bit_cnt_q <= '0;
    end
    else
    begin
      state_q <= state_d;
      if (load_i)
        bit_cnt_q <= '0;
      else if (shift)
        bit_cnt_q <= bit_cnt_q + 4'd1;
    end
  end

  // ---------------------------------------------------------------------------
  // frame register
  // ---------------------------------------------------------------------------
  // odd parity, and ones shift in behind so the wire is released after stop
  always_ff @(posedge clk)
  begin
    if (load_i)
      frame_q <= {1'b1, ~^tx_data_i, tx_data_i, 1'b0};
    else if (shift)
      frame_q <= {1'b1, frame_q[ps2_frame_pkg::frame_bits-1:1]};
  end

  // a one in the frame simply releases the data wire
  always_comb
  begin
    drive_o = '0;
    case (state_q)
      ps2_ctrl_pkg::force_clk_low:
        drive_o.clk_low = 1'b1;
      ps2_ctrl_pkg::first_wait_clk_high:
        drive_o.data_low = 1'b1;
      ps2_ctrl_pkg::clk_low,
      ps2_ctrl_pkg::wait_clk_high,
      ps2_ctrl_pkg::clk_high:
        drive_o.data_low = ~frame_q[0];
      default:
        drive_o = '0;
    endcase
  end

  assign run_long_o  = (state_q == ps2_ctrl_pkg::force_clk_low);
  assign run_short_o = (state_q == ps2_ctrl_pkg::first_wait_clk_high) ||
                       (state_q == ps2_ctrl_pkg::wait_clk_high);
  assign tx_error_o  = (state_q == ps2_ctrl_pkg::error_no_ack);

  // one-cycle pulse in the cycle both recovery states leave for idle
  assign done_o = ((state_q == ps2_ctrl_pkg::done_recovery) ||
                   (state_q == ps2_ctrl_pkg::error_no_ack)) && lines_idle;

endmodule

`default_nettype wire

//--- logic/ps2_line_arbiter.sv
// a write is granted only while receive owns the wires, so the host must hold tx_write_i until acked
`default_nettype none
`timescale 1ns/10ps

module ps2_line_arbiter (
  input  wire                           clk,
  input  wire                           reset,
  input  wire                           tx_write_i,
  input  wire ps2_frame_pkg::edge_s     edge_i,
  input  wire                           tx_done_i,
  input  wire                           rx_run_long_i,
  input  wire                           tx_run_long_i,
  input  wire                           tx_run_short_i,
  input  wire ps2_frame_pkg::drive_s    tx_drive_i,
  output logic                          owner_park_o,
  output logic                          tx_load_o,
  output logic                          tx_write_ack_o,
  output ps2_ctrl_pkg::timer_req_s      timer_req_o,
  output ps2_frame_pkg::drive_s         drive_o
);

  ps2_ctrl_pkg::owner_e owner_q;
  logic                 grant;

  // no grant in an edge cycle, where the deframer is still moving a bit
  assign grant = (owner_q == ps2_ctrl_pkg::rx) && tx_write_i &&
                 !(edge_i.fall || edge_i.rise);

  always_ff @(posedge clk or posedge reset)
  begin
    if (reset)
      owner_q <= ps2_ctrl_pkg::rx;
    else if (grant)
      owner_q <= ps2_ctrl_pkg::tx;
    else if (tx_done_i)
      owner_q <= ps2_ctrl_pkg::rx;
  end

  assign tx_load_o      = grant;
  assign tx_write_ack_o = grant;
  assign owner_park_o   = (owner_q == ps2_ctrl_pkg::tx);

  // the 60 us timer drops its enable in the grant cycle so the clock hold
  // starts from zero and not from the watchdog count
  assign timer_req_o.run_long  = owner_park_o ? tx_run_long_i : (rx_run_long_i && !grant);
  assign timer_req_o.run_short = tx_run_short_i;

  // receive never pulls a wire, so only the transmit request is forwarded
  assign drive_o = owner_park_o ? tx_drive_i : '0;

endmodule

`default_nettype wire

//--- logic/ps2_host.sv
// pad logic is outside, ps2_drive_o is an active-high pull-low request and ps2_line_i the raw wires
`default_nettype none
`timescale 1ns/10ps

module ps2_host #(
  parameter int timer_long_ticks = 2950,
  parameter int timer_long_bits  = 12
) (
  input  wire                        clk,
  input  wire                        reset,
  input  wire ps2_frame_pkg::line_s  ps2_line_i,
  input  wire [15:0]                 divide_i,
  input  wire                        rx_read_i,
  input  wire                        tx_write_i,
  input  wire ps2_frame_pkg::byte_t  tx_data_i,
  output ps2_frame_pkg::drive_s      ps2_drive_o,
  output ps2_frame_pkg::byte_t       rx_data_o,
  output logic                       rx_ready_o,
  output logic                       tx_write_ack_o,
  output logic                       tx_error_o
);

  ps2_frame_pkg::line_s      sync_line;
  ps2_frame_pkg::edge_s      sync_edge;
  ps2_frame_pkg::drive_s     tx_drive;
  ps2_ctrl_pkg::timer_req_s  timer_req;
  ps2_ctrl_pkg::timer_done_s timer_done;
  logic                      rx_park;
  logic                      rx_run_long;
  logic                      tx_load;
  logic                      tx_run_long;
  logic                      tx_run_short;
  logic                      tx_done;

  ps2_line_sync u_line_sync (
    .clk    (clk),
    .reset  (reset),
    .line_i (ps2_line_i),
    .line_o (sync_line),
    .edge_o (sync_edge)
  );

  // one pair of timers is shared, the arbiter decides whose enables count
  ps2_bit_timers #(
    .timer_long_ticks (timer_long_ticks),
    .timer_long_bits  (timer_long_bits)
  ) u_bit_timers (
    .clk      (clk),
    .reset    (reset),
    .divide_i (divide_i),
    .req_i    (timer_req),
    .done_o   (timer_done)
  );

  ps2_rx_deframer u_rx_deframer (
    .clk        (clk),
    .reset      (reset),
    .line_i     (sync_line),
    .edge_i     (sync_edge),
    .park_i     (rx_park),
    .timer_i    (timer_done),
    .rx_read_i  (rx_read_i),
    .run_long_o (rx_run_long),
    .rx_data_o  (rx_data_o),
    .rx_ready_o (rx_ready_o)
  );

  ps2_tx_framer u_tx_framer (
    .clk         (clk),
    .reset       (reset),
    .load_i      (tx_load),
    .tx_data_i   (tx_data_i),
    .line_i      (sync_line),
    .edge_i      (sync_edge),
    .timer_i     (timer_done),
    .run_long_o  (tx_run_long),
    .run_short_o (tx_run_short),
    .drive_o     (tx_drive),
    .done_o      (tx_done),
    .tx_error_o  (tx_error_o)
  );

  ps2_line_arbiter u_line_arbiter (
    .clk            (clk),
    .reset          (reset),
    .tx_write_i     (tx_write_i),
    .edge_i         (sync_edge),
    .tx_done_i      (tx_done),
    .rx_run_long_i  (rx_run_long),
    .tx_run_long_i  (tx_run_long),
    .tx_run_short_i (tx_run_short),
    .tx_drive_i     (tx_drive),
    .owner_park_o   (rx_park),
    .tx_load_o      (tx_load),
    .tx_write_ack_o (tx_write_ack_o),
    .timer_req_o    (timer_req),
    .drive_o        (ps2_drive_o)
  );

endmodule

`default_nettype wire

//--- bench/ps2_device_model.sv
// behavioural device with seeded random high times, it never times out while waiting for the host
`default_nettype none
`timescale 1ns/10ps

module ps2_device_model #(
  parameter int half_cycles = 40
) (
  input  wire                         clk,
  input  wire ps2_frame_pkg::drive_s  drive_i,
  output ps2_frame_pkg::line_s        line_o
);

  // levels the device itself puts on the wires, high means released
  logic   dev_clk;
  logic   dev_data;
  integer seed;

  // open-drain wires are low when either side pulls them low
  assign line_o = {dev_clk & ~drive_i.clk_low, dev_data & ~drive_i.data_low};

  initial
  begin
    dev_clk  = 1'b1;
    dev_data = 1'b1;
    seed     = 32'ha072_aa7d;
  end

  // returns just after a rising edge, where the wires may change safely
  task automatic wait_cycles(input int count);
    repeat (count) @(posedge clk);
    #1;
  endtask

  // extra high time before a clock pulse, 0 to 7 cycles
  function automatic int random_gap();
    return {$random(seed)} % 8;
  endfunction

  // ---------------------------------------------------------------------------
  // device to host
  // ---------------------------------------------------------------------------
  // sends the first count bits of a frame, so a count below 11 is a fragment
  task automatic send_bits(input ps2_frame_pkg::byte_t value, input int count);
    ps2_frame_pkg::frame_t frame;
    int                    i;
    frame = {1'b1, ~^value, value, 1'b0};
    wait_cycles(1);
    for (i = 0; i < count; i++)
    begin
      // data changes while the clock is high and the host samples on the fall
      dev_data = frame[i];
      wait_cycles(half_cycles + random_gap());
      dev_clk = 1'b0;
      wait_cycles(half_cycles);
      dev_clk = 1'b1;
    end
    wait_cycles(half_cycles);
    dev_data = 1'b1;
    wait_cycles(half_cycles);
  endtask

  // ---------------------------------------------------------------------------
  // host to device
  // ---------------------------------------------------------------------------
  // waits for a request to send, clocks the host frame in and answers
  task automatic take_host_frame(input bit ack, output ps2_frame_pkg::frame_t frame);
    int i;
    wait_cycles(1);
    // the host first holds the clock low, then releases it with data low
    while (!drive_i.clk_low)
      wait_cycles(1);
    while (drive_i.clk_low || !drive_i.data_low)
      wait_cycles(1);
    wait_cycles(half_cycles);
    // start, data and parity are each sampled just before the clock rises
    for (i = 0; i < ps2_frame_pkg::frame_bits - 1; i++)
    begin
      dev_clk = 1'b0;
      wait_cycles(half_cycles);
      frame[i] = line_o.data;
      dev_clk = 1'b1;
      wait_cycles(half_cycles + random_gap());
    end
    // the host has let go of data for the stop bit by now
    frame[ps2_frame_pkg::frame_bits-1] = line_o.data;
    // an acknowledge is data held low across one more clock pulse
    if (ack)
      dev_data = 1'b0;
    wait_cycles(4);
    dev_clk = 1'b0;
    wait_cycles(half_cycles);
    dev_clk = 1'b1;
    wait_cycles(4);
    dev_data = 1'b1;
    wait_cycles(half_cycles);
  endtask

endmodule

`default_nettype wire

//--- bench/ps2_host_tb.sv
// runs with divide_i of 4 and a 20 tick clock hold, tests come from bench/ps2_host_vectors.txt
`default_nettype none
`timescale 1ns/10ps

module ps2_host_tb;

  localparam int divide_setting    = 4;
  localparam int long_ticks        = 20;
  localparam int half_cycles       = 40;
  localparam int max_vectors       = 32;
  localparam int cycles_per_vector = 2000;

  logic                  clk;
  logic                  reset;
  logic [15:0]           divide;
  logic                  rx_read;
  logic                  tx_write;
  ps2_frame_pkg::byte_t  tx_data;
  ps2_frame_pkg::byte_t  rx_data;
  logic                  rx_ready;
  logic                  tx_write_ack;
  logic                  tx_error;
  ps2_frame_pkg::line_s  ps2_line;
  ps2_frame_pkg::drive_s ps2_drive;
  ps2_frame_pkg::frame_t host_frame;
  logic                  error_seen;
  logic [7:0]            vectors [0:3*max_vectors-1];
  int                    vector_count;
  int                    cycle_limit = 0;
  int                    cycle_count;

  ps2_host #(
    .timer_long_ticks (long_ticks)
  ) u_ps2_host (
    .clk            (clk),
    .reset          (reset),
    .ps2_line_i     (ps2_line),
    .divide_i       (divide),
    .rx_read_i      (rx_read),
    .tx_write_i     (tx_write),
    .tx_data_i      (tx_data),
    .ps2_drive_o    (ps2_drive),
    .rx_data_o      (rx_data),
    .rx_ready_o     (rx_ready),
    .tx_write_ack_o (tx_write_ack),
    .tx_error_o     (tx_error)
  );

  ps2_device_model #(
    .half_cycles (half_cycles)
  ) u_device (
    .clk     (clk),
    .drive_i (ps2_drive),
    .line_o  (ps2_line)
  );

  initial
  begin
    clk = 1'b0;
    forever
      #2 clk = ~clk;
  end

  // tx_error_o may be high for only part of a write, so it is latched here
  always @(negedge clk)
  begin
    if (tx_error === 1'b1)
      error_seen <= 1'b1;
  end

  // ---------------------------------------------------------------------------
  // failure reporting and compares
  // ---------------------------------------------------------------------------
  task automatic abort_run(input string reason);
    $display("%s", reason);
    $display("Test failed");
    $fatal(1, "simulation stopped at the first failure");
  endtask

  task automatic check_byte(input string test, input string what,
                            input ps2_frame_pkg::byte_t expected,
                            input ps2_frame_pkg::byte_t actual);
    if (actual !== expected)
      abort_run($sformatf("[FAIL] %s %s: expected %h, actual %h", test, what, expected, actual));
  endtask

  task automatic check_flag(input string test, input string what,
                            input bit expected, input logic actual);
    if (actual !== expected)
      abort_run($sformatf("[FAIL] %s %s: expected %b, actual %b", test, what, expected, actual));
  endtask

  task automatic check_drive(input string test, input string what,
                             input ps2_frame_pkg::drive_s expected,
                             input ps2_frame_pkg::drive_s actual);
    if (actual !== expected)
      abort_run($sformatf("[FAIL] %s %s: expected %b, actual %b", test, what, expected, actual));
  endtask

  // the parity bit makes the count of ones over byte and parity odd
  function automatic bit odd_parity(input ps2_frame_pkg::byte_t value);
    int ones;
    ones = 0;
    for (int i = 0; i < 8; i++)
      ones += value[i];
    return (ones % 2 == 0);
  endfunction

  function automatic string test_name(input logic [7:0] number);
    case (number)
      8'd1:    return "reset_state";
      8'd2:    return "rx_single";
      8'd3:    return "rx_overwrite";
      8'd4:    return "tx_ack";
      8'd5:    return "tx_no_ack";
      8'd6:    return "rx_watchdog";
      default: return "unknown";
    endcase
  endfunction

  // ---------------------------------------------------------------------------
  // operations
  // ---------------------------------------------------------------------------
  // the byte is read out only at the end of its test, so a test of two
  // frames leaves the first one unread
  task automatic receive_frame(input string test, input ps2_frame_pkg::byte_t value,
                               input bit read_out);
    u_device.send_bits(value, ps2_frame_pkg::frame_bits);
    while (rx_ready !== 1'b1)
      @(negedge clk);
    check_byte(test, "rx_data_o", value, rx_data);
    if (read_out)
    begin
      @(posedge clk);
      #1 rx_read = 1'b1;
      @(posedge clk);
      #1 rx_read = 1'b0;
      @(negedge clk);
      check_flag(test, "rx_ready_o after read", 1'b0, rx_ready);
    end
  endtask

  // holds the write strobe until the port grants it
  task automatic request_write(input ps2_frame_pkg::byte_t value);
    @(posedge clk);
    #1;
    tx_data  = value;
    tx_write = 1'b1;
    @(negedge clk);
    while (tx_write_ack !== 1'b1)
      @(negedge clk);
    @(posedge clk);
    #1 tx_write = 1'b0;
  endtask

  task automatic write_byte(input string test, input ps2_frame_pkg::byte_t value,
                            input bit ack);
    error_seen = 1'b0;
    fork
      u_device.take_host_frame(ack, host_frame);
      request_write(value);
    join
    check_flag(test, "start bit", 1'b0, host_frame[0]);
    check_byte(test, "byte seen by device", value, host_frame[8:1]);
    check_flag(test, "parity bit", odd_parity(value), host_frame[9]);
    check_flag(test, "stop bit", 1'b1, host_frame[10]);
    check_flag(test, "tx_error_o raised", !ack, error_seen);
    while (tx_error !== 1'b0)
      @(negedge clk);
    check_drive(test, "ps2_drive_o after write", '0, ps2_drive);
  endtask

  // the idle gap is longer than the 60 us timer at the current divider
  task automatic send_fragment(input string test, input ps2_frame_pkg::byte_t value);
    u_device.send_bits(value, 5);
    repeat (2 * divide_setting * long_ticks + 40) @(posedge clk);
    @(negedge clk);
    check_flag(test, "rx_ready_o after fragment", 1'b0, rx_ready);
  endtask

  // the limit is only known once the vectors are read
  initial
  begin
    cycle_count = 0;
    wait (cycle_limit != 0);
    while (cycle_count < cycle_limit)
    begin
      @(posedge clk);
      cycle_count++;
    end
    abort_run($sformatf("the run timed out after %0d cycles", cycle_count));
  end

  // ---------------------------------------------------------------------------
  // main sequence
  // ---------------------------------------------------------------------------
  initial
  begin
    logic [7:0]           op;
    logic [7:0]           test;
    ps2_frame_pkg::byte_t value;
    string                name;
    bit                   last_of_test;
    int                   v;
    reset      = 1'b1;
    divide     = 16'(divide_setting);
    rx_read    = 1'b0;
    tx_write   = 1'b0;
    tx_data    = '0;
    error_seen = 1'b0;
    // unused entries keep the end marker ff in the operation column
    for (v = 0; v < 3 * max_vectors; v++)
      vectors[v] = 8'hff;
    $readmemh("bench/ps2_host_vectors.txt", vectors);
    vector_count = 0;
    while (vector_count < max_vectors && vectors[3*vector_count] != 8'hff)
      vector_count++;
    if (vector_count == 0)
      abort_run("no vectors were read from bench/ps2_host_vectors.txt");
    cycle_limit = vector_count * cycles_per_vector;

    repeat (16) @(posedge clk);
    #1 reset = 1'b0;
    @(negedge clk);
    check_flag(test_name(1), "rx_ready_o", 1'b0, rx_ready);
    check_flag(test_name(1), "tx_write_ack_o", 1'b0, tx_write_ack);
    check_flag(test_name(1), "tx_error_o", 1'b0, tx_error);
    check_drive(test_name(1), "ps2_drive_o", '0, ps2_drive);

    for (v = 0; v < vector_count; v++)
    begin
      op           = vectors[3*v];
      value        = vectors[3*v+1];
      test         = vectors[3*v+2];
      name         = test_name(test);
      last_of_test = (v == vector_count - 1) || (vectors[3*v+5] != test);
      case (op)
        8'h0:    receive_frame(name, value, last_of_test);
        8'h1:    write_byte(name, value, 1'b1);
        8'h2:    write_byte(name, value, 1'b0);
        8'h3:    send_fragment(name, value);
        default: abort_run($sformatf("vector %0d has an unknown operation %h", v, op));
      endcase
    end

    $display("Test passed");
    $finish;
  end

endmodule

`default_nettype wire

//--- sim.f
logic/ps2_frame_pkg.sv
logic/ps2_ctrl_pkg.sv
logic/ps2_line_sync.sv
logic/ps2_bit_timers.sv
logic/ps2_rx_deframer.sv
logic/ps2_tx_framer.sv
logic/ps2_line_arbiter.sv
logic/ps2_host.sv
bench/ps2_device_model.sv
bench/ps2_host_tb.sv

//--- Bender.yml
package:
  name: ps2_host

sources:
  - logic/ps2_frame_pkg.sv
  - logic/ps2_ctrl_pkg.sv
  - logic/ps2_line_sync.sv
  - logic/ps2_bit_timers.sv
  - logic/ps2_rx_deframer.sv
  - logic/ps2_tx_framer.sv
  - logic/ps2_line_arbiter.sv
  - logic/ps2_host.sv
  - target: simulation
    files:
      - bench/ps2_device_model.sv
      - bench/ps2_host_tb.sv

//--- bench/ps2_host_vectors.txt
// columns: operation, byte, test number, all hex
// operation 0 device frame, 1 acked host write, 2 unacked host write, 3 device fragment
0 a5 2
0 3c 3
0 c3 3
1 f4 4
0 fa 4
2 ed 5
0 81 5
3 5a 6
0 aa 6
1 00 4
0 7e 4
0 ff 2
